// ==== Bender.yml ====
package:
  name: sal_bank_queues

sources:
  - include_dirs:
      - common
    files:
      - common/sal_pkg.sv
      - bank_queue/sal_sa_fifo.sv
      - logic/sal_req_dispatch.sv
      - logic/sal_bank_arbiter.sv
      - logic/sal_bank_queues_top.sv
      - target: test
        files:
          - verif/sal_tb_checker.sv
          - verif/sal_tb_top.sv

// ==== bank_queue/sal_sa_fifo.sv ====
// synchronous FIFO with a type-parameterized payload
// registered full, empty and almost-full flags, combinational head read

`timescale 1ns/1ps

module sal_sa_fifo #(
  parameter int  DEPTH_LG2   = 2,
  parameter int  AFULL_THRES = 3,
  parameter type payload_t   = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wren_i,
  input  payload_t wdata_i,
  input  logic     rden_i,
  output payload_t rdata_o,
  output logic     full_o,
  output logic     afull_o,
  output logic     empty_o
);

  localparam int DEPTH = 2 ** DEPTH_LG2;

  payload_t mem [DEPTH];

  // one extra bit on each pointer tells full from empty
  logic [DEPTH_LG2:0] wr_ptr;
  logic [DEPTH_LG2:0] wr_ptr_n;
  logic [DEPTH_LG2:0] rd_ptr;
  logic [DEPTH_LG2:0] rd_ptr_n;
  logic [DEPTH_LG2:0] cnt;
  logic [DEPTH_LG2:0] cnt_n;

  logic push;
  logic pop;
  logic full_n;
  logic afull_n;
  logic empty_n;

  // never write past full or read past empty
  assign push = wren_i & ~full_o;
  assign pop  = rden_i & ~empty_o;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[DEPTH_LG2-1:0]] <= wdata_i;
    end
  end

  always_comb begin
    if (push) begin
      wr_ptr_n = wr_ptr + 1'b1;
    end else begin
      wr_ptr_n = wr_ptr;
    end

    if (pop) begin
      rd_ptr_n = rd_ptr + 1'b1;
    end else begin
      rd_ptr_n = rd_ptr;
    end

    if (push && !pop) begin
      cnt_n = cnt + 1'b1;
    end else if (!push && pop) begin
      cnt_n = cnt - 1'b1;
    end else begin
      cnt_n = cnt;
    end

    full_n  = (wr_ptr_n[DEPTH_LG2] != rd_ptr_n[DEPTH_LG2]) &&
              (wr_ptr_n[DEPTH_LG2-1:0] == rd_ptr_n[DEPTH_LG2-1:0]);
    empty_n = (wr_ptr_n == rd_ptr_n);
    afull_n = (int'(cnt_n) >= AFULL_THRES);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      cnt     <= '0;
      full_o  <= 1'b0;
      afull_o <= 1'b0;
      empty_o <= 1'b1;
    end else begin
      wr_ptr  <= wr_ptr_n;
      rd_ptr  <= rd_ptr_n;
      cnt     <= cnt_n;
      full_o  <= full_n;
      afull_o <= afull_n;
      empty_o <= empty_n;
    end
  end

  // head of queue, valid while empty_o is low
  assign rdata_o = mem[rd_ptr[DEPTH_LG2-1:0]];

endmodule

// ==== common/sal_macros.svh ====
// bank count, per-bank queue depth and almost-full threshold
// bank index width derived from the bank count

`ifndef SAL_MACROS_SVH
`define SAL_MACROS_SVH

// number of banks, one queue each
`define SAL_NUM_BANKS 4

// log2 of entries per bank queue
`define SAL_QUEUE_DEPTH_LG2 2

// occupancy at which almost-full asserts
`define SAL_AFULL_THRES 3

// width of a bank index
`define SAL_BANK_BITS $clog2(`SAL_NUM_BANKS)

`endif

// ==== common/sal_pkg.sv ====
// request payload struct and bank index type
// field widths of the request

`include "sal_macros.svh"

package sal_pkg;

  localparam int ROW_W = 14;
  localparam int COL_W = 10;
  localparam int TAG_W = 6;

  typedef logic [`SAL_BANK_BITS-1:0] bank_idx_t;

  // bank is implied by the queue the request sits in
  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic             wr;
    logic [TAG_W-1:0] tag;
  } sal_req_t;

endpackage

// ==== logic/sal_bank_arbiter.sv ====
// round-robin pop over non-empty bank queues
// registered command output with bank number and request fields

`timescale 1ns/1ps

`include "sal_macros.svh"

module sal_bank_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`SAL_NUM_BANKS-1:0] bank_empty_i,
  input  sal_pkg::sal_req_t         bank_head_i [`SAL_NUM_BANKS],
  output logic [`SAL_NUM_BANKS-1:0] rden_o,
  output logic                      cmd_valid_o,
  output sal_pkg::bank_idx_t        cmd_bank_o,
  output logic [sal_pkg::ROW_W-1:0] cmd_row_o,
  output logic [sal_pkg::COL_W-1:0] cmd_col_o,
  output logic                      cmd_wr_o,
  output logic [sal_pkg::TAG_W-1:0] cmd_tag_o
);

  import sal_pkg::*;

  localparam int NB = `SAL_NUM_BANKS;

  bank_idx_t last_gnt;
  bank_idx_t gnt_idx;
  logic      gnt_vld;
  sal_req_t  head_sel;

  // first non-empty bank after the last grant, wrapping
  always_comb begin
    int cand;
    gnt_vld = 1'b0;
    gnt_idx = last_gnt;
    for (int i = 1; i <= NB; i++) begin
      cand = (int'(last_gnt) + i) % NB;
      if (!gnt_vld && !bank_empty_i[cand]) begin
        gnt_vld = 1'b1;
        gnt_idx = bank_idx_t'(cand);
      end
    end
  end

  always_comb begin
    rden_o = '0;
    if (gnt_vld) begin
      rden_o[gnt_idx] = 1'b1;
    end
  end

  assign head_sel = bank_head_i[gnt_idx];

  // pointer starts on the last bank so bank 0 goes first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid_o <= 1'b0;
      last_gnt    <= bank_idx_t'(NB - 1);
    end else begin
      cmd_valid_o <= gnt_vld;
      if (gnt_vld) begin
        last_gnt <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_vld) begin
      cmd_bank_o <= gnt_idx;
      cmd_row_o  <= head_sel.row;
      cmd_col_o  <= head_sel.col;
      cmd_wr_o   <= head_sel.wr;
      cmd_tag_o  <= head_sel.tag;
    end
  end

endmodule

// ==== logic/sal_bank_queues_top.sv ====
// per-bank request queue stage
// dispatcher, one FIFO per bank, round-robin arbiter

`timescale 1ns/1ps

`include "sal_macros.svh"

module sal_bank_queues_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid_i,
  input  sal_pkg::bank_idx_t        req_bank_i,
  input  logic [sal_pkg::ROW_W-1:0] req_row_i,
  input  logic [sal_pkg::COL_W-1:0] req_col_i,
  input  logic                      req_wr_i,
  input  logic [sal_pkg::TAG_W-1:0] req_tag_i,
  output logic                      cmd_valid_o,
  output sal_pkg::bank_idx_t        cmd_bank_o,
  output logic [sal_pkg::ROW_W-1:0] cmd_row_o,
  output logic [sal_pkg::COL_W-1:0] cmd_col_o,
  output logic                      cmd_wr_o,
  output logic [sal_pkg::TAG_W-1:0] cmd_tag_o,
  output logic [`SAL_NUM_BANKS-1:0] bank_afull_o,
  output logic [15:0]               drop_cnt_o
);

  import sal_pkg::*;

  logic [`SAL_NUM_BANKS-1:0] wren;
  logic [`SAL_NUM_BANKS-1:0] rden;
  logic [`SAL_NUM_BANKS-1:0] bank_full;
  logic [`SAL_NUM_BANKS-1:0] bank_empty;
  sal_req_t                  wdata;
  sal_req_t                  bank_head [`SAL_NUM_BANKS];

  sal_req_dispatch u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_bank_i  (req_bank_i),
    .req_row_i   (req_row_i),
    .req_col_i   (req_col_i),
    .req_wr_i    (req_wr_i),
    .req_tag_i   (req_tag_i),
    .bank_full_i (bank_full),
    .wren_o      (wren),
    .wdata_o     (wdata),
    .drop_cnt_o  (drop_cnt_o)
  );

  for (genvar k = 0; k < `SAL_NUM_BANKS; k++) begin : g_bank
    sal_sa_fifo #(
      .DEPTH_LG2   (`SAL_QUEUE_DEPTH_LG2),
      .AFULL_THRES (`SAL_AFULL_THRES),
      .payload_t   (sal_req_t)
    ) u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .wren_i  (wren[k]),
      .wdata_i (wdata),
      .rden_i  (rden[k]),
      .rdata_o (bank_head[k]),
      .full_o  (bank_full[k]),
      .afull_o (bank_afull_o[k]),
      .empty_o (bank_empty[k])
    );
  end

  sal_bank_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank_empty_i (bank_empty),
    .bank_head_i  (bank_head),
    .rden_o       (rden),
    .cmd_valid_o  (cmd_valid_o),
    .cmd_bank_o   (cmd_bank_o),
    .cmd_row_o    (cmd_row_o),
    .cmd_col_o    (cmd_col_o),
    .cmd_wr_o     (cmd_wr_o),
    .cmd_tag_o    (cmd_tag_o)
  );

endmodule

// ==== logic/sal_req_dispatch.sv ====
// bank decode of incoming requests into per-bank write enables
// saturating count of requests dropped on a full queue

`timescale 1ns/1ps

`include "sal_macros.svh"

module sal_req_dispatch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid_i,
  input  sal_pkg::bank_idx_t        req_bank_i,
  input  logic [sal_pkg::ROW_W-1:0] req_row_i,
  input  logic [sal_pkg::COL_W-1:0] req_col_i,
  input  logic                      req_wr_i,
  input  logic [sal_pkg::TAG_W-1:0] req_tag_i,
  input  logic [`SAL_NUM_BANKS-1:0] bank_full_i,
  output logic [`SAL_NUM_BANKS-1:0] wren_o,
  output sal_pkg::sal_req_t         wdata_o,
  output logic [15:0]               drop_cnt_o
);

  import sal_pkg::*;

  sal_req_t req_packed;
  logic     drop;

  always_comb begin
    req_packed.row = req_row_i;
    req_packed.col = req_col_i;
    req_packed.wr  = req_wr_i;
    req_packed.tag = req_tag_i;
  end

  // payload goes to every queue, only one gets the write
  assign wdata_o = req_packed;

  always_comb begin
    wren_o = '0;
    if (req_valid_i && !bank_full_i[req_bank_i]) begin
      wren_o[req_bank_i] = 1'b1;
    end
  end

  assign drop = req_valid_i & bank_full_i[req_bank_i];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_cnt_o <= '0;
    end else if (drop && (drop_cnt_o != 16'hffff)) begin
      drop_cnt_o <= drop_cnt_o + 16'd1;
    end
  end

endmodule

// ==== tb.f ====
+incdir+common
common/sal_pkg.sv
bank_queue/sal_sa_fifo.sv
logic/sal_req_dispatch.sv
logic/sal_bank_arbiter.sv
logic/sal_bank_queues_top.sv
verif/sal_tb_checker.sv
verif/sal_tb_top.sv

// ==== verif/sal_tb_checker.sv ====
// reference model of the per-bank queues
// checks command order, drops, almost-full, idle latency, fairness and drain

`timescale 1ns/1ps

`include "sal_macros.svh"

module sal_tb_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid_i,
  input  sal_pkg::bank_idx_t        req_bank_i,
  input  logic [sal_pkg::ROW_W-1:0] req_row_i,
  input  logic [sal_pkg::COL_W-1:0] req_col_i,
  input  logic                      req_wr_i,
  input  logic [sal_pkg::TAG_W-1:0] req_tag_i,
  input  logic                      cmd_valid_i,
  input  sal_pkg::bank_idx_t        cmd_bank_i,
  input  logic [sal_pkg::ROW_W-1:0] cmd_row_i,
  input  logic [sal_pkg::COL_W-1:0] cmd_col_i,
  input  logic                      cmd_wr_i,
  input  logic [sal_pkg::TAG_W-1:0] cmd_tag_i,
  input  logic [`SAL_NUM_BANKS-1:0] bank_afull_i,
  input  logic [15:0]               drop_cnt_i,
  input  logic                      stim_done_i,
  output logic                      drain_done_o,
  output int                        val_err_o,
  output int                        other_err_o
);

  import sal_pkg::*;

  localparam int NB          = `SAL_NUM_BANKS;
  localparam int DEPTH       = 2 ** `SAL_QUEUE_DEPTH_LG2;
  localparam int STIM_LIMIT  = 5000;
  localparam int DRAIN_LIMIT = 100;

  sal_req_t mq [NB][DEPTH];
  int       head [NB];
  int       occ [NB];
  int       drops;
  int       last_bank;
  logic     all_busy_q;
  int       cyc;
  int       idle_due;
  int       idle_bank;
  int       val_err = 0;
  int       proto_err = 0;
  int       drain_err = 0;

  assign val_err_o   = val_err;
  assign other_err_o = proto_err + drain_err;

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      val_err++;
    end
  endtask

  // sampled at the falling edge with commands handled first
  // so the model occupancy tracks the FIFO counts
  always @(negedge clk) begin
    sal_req_t exp_req;
    int       b;
    logic     busy;
    logic     all_empty;
    if (rst_n !== 1'b1) begin
      for (int k = 0; k < NB; k++) begin
        head[k] = 0;
        occ[k]  = 0;
      end
      drops      = 0;
      last_bank  = NB - 1;
      all_busy_q = 1'b0;
      cyc        = 0;
      idle_due   = -1;
    end else begin
      cyc++;
      if (cmd_valid_i) begin
        b = int'(cmd_bank_i);
        // grant was made while every queue held a request
        if (all_busy_q) begin
          check_val("cmd_bank_o", b, (last_bank + 1) % NB);
        end
        if (occ[b] == 0) begin
          $display("command issued for bank %0d while its queue should be empty", b);
          proto_err++;
        end else begin
          exp_req = mq[b][head[b]];
          check_val("cmd_row_o", cmd_row_i, exp_req.row);
          check_val("cmd_col_o", cmd_col_i, exp_req.col);
          check_val("cmd_wr_o", cmd_wr_i, exp_req.wr);
          check_val("cmd_tag_o", cmd_tag_i, exp_req.tag);
          head[b] = (head[b] + 1) % DEPTH;
          occ[b]--;
        end
        last_bank = b;
      end
      if (idle_due == cyc) begin
        if (!cmd_valid_i) begin
          $display("request into empty queues was not issued two cycles later");
          proto_err++;
        end else begin
          check_val("cmd_bank_o", cmd_bank_i, idle_bank);
        end
        idle_due = -1;
      end
      busy      = 1'b1;
      all_empty = 1'b1;
      for (int k = 0; k < NB; k++) begin
        check_val($sformatf("bank_afull_o[%0d]", k), bank_afull_i[k],
                  occ[k] >= `SAL_AFULL_THRES);
        if (occ[k] == 0) begin
          busy = 1'b0;
        end else begin
          all_empty = 1'b0;
        end
      end
      all_busy_q = busy;
      check_val("drop_cnt_o", drop_cnt_i, drops);
      if (req_valid_i) begin
        b = int'(req_bank_i);
        if (occ[b] == DEPTH) begin
          drops++;
        end else begin
          if (all_empty) begin
            idle_due  = cyc + 2;
            idle_bank = b;
          end
          exp_req.row = req_row_i;
          exp_req.col = req_col_i;
          exp_req.wr  = req_wr_i;
          exp_req.tag = req_tag_i;
          mq[b][(head[b] + occ[b]) % DEPTH] = exp_req;
          occ[b]++;
        end
      end
    end
  end

  initial begin
    int waited;
    int pending;
    drain_done_o = 1'b0;
    waited       = 0;
    while (!stim_done_i && waited < STIM_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!stim_done_i) begin
      $display("stimulus did not finish within %0d cycles", STIM_LIMIT);
      drain_err++;
    end
    waited  = 0;
    pending = 1;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
      pending = 0;
      for (int k = 0; k < NB; k++) begin
        pending += occ[k];
      end
    end
    for (int k = 0; k < NB; k++) begin
      if (occ[k] != 0) begin
        $display("bank %0d still holds %0d requests after the drain timeout", k, occ[k]);
        drain_err++;
      end
    end
    drain_done_o = 1'b1;
  end

endmodule

// ==== verif/sal_tb_top.sv ====
// testbench top with clock, reset and random request stimulus
// DUT, checker and closing report

`timescale 1ns/1ps

`include "sal_macros.svh"

module sal_tb_top;

  import sal_pkg::*;

  localparam int NB         = `SAL_NUM_BANKS;
  localparam int PHASE_LEN  = 120;
  localparam int NUM_PHASES = 6;
  localparam int DONE_LIMIT = 2000;

  logic                      clk;
  logic                      rst_n;
  logic                      req_valid;
  bank_idx_t                 req_bank;
  logic [ROW_W-1:0]          req_row;
  logic [COL_W-1:0]          req_col;
  logic                      req_wr;
  logic [TAG_W-1:0]          req_tag;
  logic                      cmd_valid;
  bank_idx_t                 cmd_bank;
  logic [ROW_W-1:0]          cmd_row;
  logic [COL_W-1:0]          cmd_col;
  logic                      cmd_wr;
  logic [TAG_W-1:0]          cmd_tag;
  logic [`SAL_NUM_BANKS-1:0] bank_afull;
  logic [15:0]               drop_cnt;
  logic                      stim_done;
  logic                      drain_done;
  int                        val_err;
  int                        other_err;
  logic [31:0]               lcg_state;

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  sal_bank_queues_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_bank_i   (req_bank),
    .req_row_i    (req_row),
    .req_col_i    (req_col),
    .req_wr_i     (req_wr),
    .req_tag_i    (req_tag),
    .cmd_valid_o  (cmd_valid),
    .cmd_bank_o   (cmd_bank),
    .cmd_row_o    (cmd_row),
    .cmd_col_o    (cmd_col),
    .cmd_wr_o     (cmd_wr),
    .cmd_tag_o    (cmd_tag),
    .bank_afull_o (bank_afull),
    .drop_cnt_o   (drop_cnt)
  );

  sal_tb_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_bank_i   (req_bank),
    .req_row_i    (req_row),
    .req_col_i    (req_col),
    .req_wr_i     (req_wr),
    .req_tag_i    (req_tag),
    .cmd_valid_i  (cmd_valid),
    .cmd_bank_i   (cmd_bank),
    .cmd_row_i    (cmd_row),
    .cmd_col_i    (cmd_col),
    .cmd_wr_i     (cmd_wr),
    .cmd_tag_i    (cmd_tag),
    .bank_afull_i (bank_afull),
    .drop_cnt_i   (drop_cnt),
    .stim_done_i  (stim_done),
    .drain_done_o (drain_done),
    .val_err_o    (val_err),
    .other_err_o  (other_err)
  );

  initial begin
    logic [15:0] r;
    int          waited;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_bank  = '0;
    req_row   = '0;
    req_col   = '0;
    req_wr    = 1'b0;
    req_tag   = '0;
    stim_done = 1'b0;
    lcg_state = 32'd95;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // even phases busy, odd phases sparse
    for (int p = 0; p < NUM_PHASES; p++) begin
      for (int i = 0; i < PHASE_LEN; i++) begin
        @(posedge clk);
        #2;
        r = lcg_next();
        req_valid = (p % 2 == 0) ? (r[15:13] != 3'd0) : (r[15:12] == 4'd0);
        r = lcg_next();
        req_row = r[13:0];
        req_wr  = r[14];
        r = lcg_next();
        req_col = r[9:0];
        req_tag = r[15:10];
        r = lcg_next();
        req_bank = bank_idx_t'(r % NB);
      end
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    stim_done = 1'b1;
    waited    = 0;
    while (!drain_done && waited < DONE_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!drain_done) begin
      $display("checker did not finish within %0d cycles after stimulus", DONE_LIMIT);
    end
    $display("errors: value mismatches %0d, other failures %0d", val_err, other_err);
    if (drain_done && val_err == 0 && other_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
